/* lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 32

// byte lanes per word
`define LSU_LANES 4

// data ram geometry, depth in words
`define LSU_RAM_WORDS 256
`define LSU_RAM_ABITS 8

// cycles from request rise to the completion level
`define LSU_RAM_LATENCY 2
`define LSU_LAT_BITS 4

// register file index
`define LSU_REG_BITS 5

// encoded field widths in the control word
`define LSU_OP_BITS 3
`define LSU_SIZE_BITS 2

`endif

/* lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [`LSU_LANES-1:0] byte_mask_t;
    typedef logic [`LSU_REG_BITS-1:0] reg_idx_t;

    // memory operation carried by the execute stage
    typedef enum logic [`LSU_OP_BITS-1:0] {
        NONE        = 3'd0,
        LOAD        = 3'd1,
        STORE       = 3'd2,
        LOAD_LINKED = 3'd3,
        STORE_COND  = 3'd4
    } mem_op_e;

    typedef enum logic [`LSU_SIZE_BITS-1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // word handed over from execute
    typedef struct packed {
        word_t     pc;
        word_t     alu_result;
        word_t     store_data;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      unsigned_ext;
        reg_idx_t  wreg_idx;
        logic      wreg_en;
    } ex_mem_ctrl_t;

    typedef struct packed {
        logic      is_mem;
        logic      is_load;
        logic      is_store;
        logic      is_ll;
        logic      is_sc;
        mem_size_e size;
        logic      unsigned_ext;
    } mem_decoded_t;

    // registered word toward writeback
    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t wreg_idx;
        logic     wreg_en;
    } mem_wb_ctrl_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t wreg_idx;
        logic     wen;
    } mem_bypass_t;

endpackage

/* mem_op_decode.sv */
`timescale 1ns/1ns

module mem_op_decode import lsu_pkg::*; (
    input  ex_mem_ctrl_t ex_ctrl_i,
    output mem_decoded_t dec_o
);

    always_comb begin
        dec_o              = '0;
        dec_o.size         = ex_ctrl_i.mem_size;
        dec_o.unsigned_ext = ex_ctrl_i.unsigned_ext;

        unique case (ex_ctrl_i.mem_op)
            LOAD: begin
                dec_o.is_mem  = 1'b1;
                dec_o.is_load = 1'b1;
            end
            STORE: begin
                dec_o.is_mem   = 1'b1;
                dec_o.is_store = 1'b1;
            end
            // ll is a load that also arms the ll bit
            LOAD_LINKED: begin
                dec_o.is_mem  = 1'b1;
                dec_o.is_load = 1'b1;
                dec_o.is_ll   = 1'b1;
            end
            // sc is a store whose result is the ll status
            STORE_COND: begin
                dec_o.is_mem   = 1'b1;
                dec_o.is_store = 1'b1;
                dec_o.is_sc    = 1'b1;
            end
            default: begin
                dec_o.is_mem = 1'b0;
            end
        endcase

        // ll and sc always move a full word
        if (dec_o.is_ll || dec_o.is_sc) begin
            dec_o.size = WORD;
        end
    end

endmodule

/* mem_access_exec.sv */
`timescale 1ns/1ns

module mem_access_exec import lsu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         left_valid_i,
    input  ex_mem_ctrl_t ex_ctrl_i,
    input  mem_decoded_t dec_i,
    input  logic         right_ready_i,
    input  word_t        ram_rdata_i,
    input  logic         rdata_valid_i,
    input  logic         write_finish_i,
    output logic         ram_req_o,
    output logic         ram_we_o,
    output word_t        ram_addr_o,
    output word_t        ram_wdata_o,
    output byte_mask_t   ram_wmask_o,
    output word_t        load_word_o,
    output logic         access_done_o,
    output logic         llbit_o,
    output logic         left_ready_o
);

    logic  llbit_q;
    logic  done_q;
    logic  flush_q;
    word_t hold_q;
    logic  sc_fail;
    logic  need_access;
    logic  pending;
    logic  completion;
    logic  fire;

    // failed sc never reaches the ram
    assign sc_fail     = dec_i.is_sc & ~llbit_q;
    assign need_access = dec_i.is_mem & ~sc_fail;
    assign pending     = left_valid_i & need_access & ~done_q;

    // request level, dropped for one cycle after a flush so the ram restarts
    assign ram_req_o  = pending & ~flush_q;
    assign ram_we_o   = dec_i.is_store;
    assign ram_addr_o = ex_ctrl_i.alu_result;

    assign completion = ram_req_o & (dec_i.is_store ? write_finish_i : rdata_valid_i);

    assign access_done_o = left_valid_i & ~flush_i & (~need_access | done_q | completion);
    assign left_ready_o  = ~(pending & ~completion);
    assign fire          = access_done_o & right_ready_i;

    assign llbit_o     = llbit_q;
    assign load_word_o = done_q ? hold_q : ram_rdata_i;

    // lane alignment of store data and byte enables
    always_comb begin
        unique case (dec_i.size)
            BYTE: begin
                ram_wdata_o = {4{ex_ctrl_i.store_data[7:0]}};
                ram_wmask_o = byte_mask_t'(4'b0001 << ex_ctrl_i.alu_result[1:0]);
            end
            HALF: begin
                ram_wdata_o = {2{ex_ctrl_i.store_data[15:0]}};
                ram_wmask_o = ex_ctrl_i.alu_result[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ram_wdata_o = ex_ctrl_i.store_data;
                ram_wmask_o = 4'b1111;
            end
        endcase
    end

    // access already satisfied while the output stalls
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q  <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush_i;
            if (flush_i || fire) begin
                done_q <= 1'b0;
            end else if (completion) begin
                done_q <= 1'b1;
            end
        end
    end

    // ll bit follows the instruction that retires
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            llbit_q <= 1'b0;
        end else if (fire) begin
            if (dec_i.is_ll) begin
                llbit_q <= 1'b1;
            end else if (dec_i.is_sc) begin
                llbit_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_req_o && rdata_valid_i) begin
            hold_q <= ram_rdata_i;
        end
    end

endmodule

/* load_result.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module load_result import lsu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         left_valid_i,
    input  ex_mem_ctrl_t ex_ctrl_i,
    input  mem_decoded_t dec_i,
    input  word_t        load_word_i,
    input  logic         access_done_i,
    input  logic         llbit_i,
    input  logic         right_ready_i,
    output mem_wb_ctrl_t wb_ctrl_o,
    output logic         right_valid_o,
    output logic         is_fire_o,
    output mem_bypass_t  bypass_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       load_ext;
    word_t       result;
    logic        fire;

    // lane pick by low address bits
    always_comb begin
        unique case (ex_ctrl_i.alu_result[1:0])
            2'd0: byte_sel = load_word_i[7:0];
            2'd1: byte_sel = load_word_i[15:8];
            2'd2: byte_sel = load_word_i[23:16];
            default: byte_sel = load_word_i[31:24];
        endcase
        half_sel = ex_ctrl_i.alu_result[1] ? load_word_i[31:16] : load_word_i[15:0];
    end

    always_comb begin
        unique case (dec_i.size)
            BYTE: begin
                if (dec_i.unsigned_ext) begin
                    load_ext = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
                end else begin
                    load_ext = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
                end
            end
            HALF: begin
                if (dec_i.unsigned_ext) begin
                    load_ext = {{(`LSU_XLEN-16){1'b0}}, half_sel};
                end else begin
                    load_ext = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
                end
            end
            default: load_ext = load_word_i;
        endcase
    end

    // sc reports the ll bit it saw, loads their data, the rest the alu value
    assign result = dec_i.is_sc   ? word_t'(llbit_i) :
                    dec_i.is_load ? load_ext :
                                    ex_ctrl_i.alu_result;

    assign fire      = left_valid_i & access_done_i & right_ready_i;
    assign is_fire_o = fire;

    assign bypass_o.result   = result;
    assign bypass_o.wreg_idx = ex_ctrl_i.wreg_idx;
    assign bypass_o.wen      = ex_ctrl_i.wreg_en & left_valid_i & access_done_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            right_valid_o <= 1'b0;
        end else if (flush_i) begin
            right_valid_o <= 1'b0;
        end else if (fire) begin
            right_valid_o <= 1'b1;
        end else if (right_ready_i) begin
            right_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            wb_ctrl_o.pc       <= ex_ctrl_i.pc;
            wb_ctrl_o.result   <= result;
            wb_ctrl_o.wreg_idx <= ex_ctrl_i.wreg_idx;
            wb_ctrl_o.wreg_en  <= ex_ctrl_i.wreg_en;
        end
    end

endmodule

/* data_ram.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module data_ram import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       req_i,
    input  logic       we_i,
    input  word_t      addr_i,
    input  word_t      wdata_i,
    input  byte_mask_t wmask_i,
    output word_t      rdata_o,
    output logic       rdata_valid_o,
    output logic       write_finish_o
);

    word_t mem [0:`LSU_RAM_WORDS-1];

    logic [`LSU_LAT_BITS-1:0]  lat_cnt;
    logic [`LSU_RAM_ABITS-1:0] word_idx;
    logic                      ack_now;
    logic                      slot;

    assign word_idx = addr_i[`LSU_RAM_ABITS+1:2];
    assign ack_now  = rdata_valid_o | write_finish_o;
    // last waiting cycle, the access happens on this edge
    assign slot     = req_i & ~ack_now & (lat_cnt == `LSU_RAM_LATENCY - 1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lat_cnt        <= '0;
            rdata_valid_o  <= 1'b0;
            write_finish_o <= 1'b0;
        end else if (ack_now || !req_i) begin
            // one-cycle completion level, then wait for a fresh request
            lat_cnt        <= '0;
            rdata_valid_o  <= 1'b0;
            write_finish_o <= 1'b0;
        end else if (slot) begin
            lat_cnt        <= '0;
            rdata_valid_o  <= ~we_i;
            write_finish_o <= we_i;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (slot) begin
            rdata_o <= mem[word_idx];
            if (we_i) begin
                for (int i = 0; i < `LSU_LANES; i++) begin
                    if (wmask_i[i]) begin
                        mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

/* mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top import lsu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         left_valid_i,
    input  ex_mem_ctrl_t ex_ctrl_i,
    output logic         left_ready_o,
    input  logic         right_ready_i,
    output logic         right_valid_o,
    output mem_wb_ctrl_t wb_ctrl_o,
    output logic         is_fire_o,
    output mem_bypass_t  bypass_o
);

    mem_decoded_t dec;
    word_t        ram_addr;
    word_t        ram_wdata;
    word_t        ram_rdata;
    word_t        load_word;
    byte_mask_t   ram_wmask;
    logic         ram_req;
    logic         ram_we;
    logic         rdata_valid;
    logic         write_finish;
    logic         access_done;
    logic         llbit;

    mem_op_decode u_decode (
        .ex_ctrl_i (ex_ctrl_i),
        .dec_o     (dec)
    );

    mem_access_exec u_exec (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .left_valid_i   (left_valid_i),
        .ex_ctrl_i      (ex_ctrl_i),
        .dec_i          (dec),
        .right_ready_i  (right_ready_i),
        .ram_rdata_i    (ram_rdata),
        .rdata_valid_i  (rdata_valid),
        .write_finish_i (write_finish),
        .ram_req_o      (ram_req),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_wmask_o    (ram_wmask),
        .load_word_o    (load_word),
        .access_done_o  (access_done),
        .llbit_o        (llbit),
        .left_ready_o   (left_ready_o)
    );

    load_result u_result (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .left_valid_i  (left_valid_i),
        .ex_ctrl_i     (ex_ctrl_i),
        .dec_i         (dec),
        .load_word_i   (load_word),
        .access_done_i (access_done),
        .llbit_i       (llbit),
        .right_ready_i (right_ready_i),
        .wb_ctrl_o     (wb_ctrl_o),
        .right_valid_o (right_valid_o),
        .is_fire_o     (is_fire_o),
        .bypass_o      (bypass_o)
    );

    data_ram u_ram (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (ram_req),
        .we_i           (ram_we),
        .addr_i         (ram_addr),
        .wdata_i        (ram_wdata),
        .wmask_i        (ram_wmask),
        .rdata_o        (ram_rdata),
        .rdata_valid_o  (rdata_valid),
        .write_finish_o (write_finish)
    );

endmodule

/* mem_stage_assertions.sv */
`timescale 1ns/1ns

module mem_stage_assertions import lsu_pkg::*; (
    input logic         clk,
    input logic         rst_n_i,
    input logic         flush_i,
    input logic         ram_req,
    input logic         rdata_valid,
    input logic         write_finish,
    input logic         right_ready_i,
    input logic         right_valid_o,
    input mem_wb_ctrl_t wb_ctrl_o
);

    // request is a level until the ram answers
    property req_held;
        @(posedge clk) disable iff (!rst_n_i)
            ram_req && !rdata_valid && !write_finish && !flush_i |=> ram_req;
    endproperty

    property flush_clears_valid;
        @(posedge clk) disable iff (!rst_n_i)
            flush_i |=> !right_valid_o;
    endproperty

    // held word under back-pressure
    property wb_stable;
        @(posedge clk) disable iff (!rst_n_i)
            right_valid_o && !right_ready_i |=> $stable(wb_ctrl_o);
    endproperty

    a_req_held: assert property (req_held) else $error("ram request dropped early");
    a_flush:    assert property (flush_clears_valid) else $error("valid after flush");
    a_wb:       assert property (wb_stable) else $error("wb word changed while stalled");

endmodule

bind mem_stage_top mem_stage_assertions u_assert (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .ram_req       (ram_req),
    .rdata_valid   (rdata_valid),
    .write_finish  (write_finish),
    .right_ready_i (right_ready_i),
    .right_valid_o (right_valid_o),
    .wb_ctrl_o     (wb_ctrl_o)
);

/* tb_mem_stage.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module tb_mem_stage import lsu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_LIMIT = 40;

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        logic      uns;
        word_t     addr;
        word_t     data;
        reg_idx_t  wreg;
        logic [1:0] hold;
        logic      flush;
    } entry_t;

    logic         clk;
    logic         rst_n_i;
    logic         flush_i;
    logic         left_valid_i;
    ex_mem_ctrl_t ex_ctrl_i;
    logic         left_ready_o;
    logic         right_ready_i;
    logic         right_valid_o;
    mem_wb_ctrl_t wb_ctrl_o;
    logic         is_fire_o;
    mem_bypass_t  bypass_o;

    entry_t       tbl [$];
    logic [7:0]   ref_mem [0:1023];
    logic         ref_ll;
    logic [31:0]  lfsr;
    int           errors;
    int           fire_count;
    int           expected_fires;

    mem_stage_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (is_fire_o) begin
            fire_count++;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic add_entry(input mem_op_e op, input mem_size_e size, input logic uns,
                             input word_t addr, input logic flush);
        entry_t e;
        e.op    = op;
        e.size  = size;
        e.uns   = uns;
        e.addr  = addr;
        e.data  = take_bits(32);
        e.wreg  = reg_idx_t'(take_bits(5));
        e.hold  = 2'(take_bits(2));
        e.flush = flush;
        tbl.push_back(e);
    endtask

    function automatic word_t read_word(word_t a);
        logic [9:0] b;
        b = {a[9:2], 2'b00};
        return {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
    endfunction

    // expected result of one entry and the reference state after it
    task automatic model_entry(input entry_t e, output word_t exp);
        logic [9:0]  b;
        word_t       w;
        logic [15:0] h;
        logic [7:0]  y;
        b = e.addr[9:0];
        w = read_word(e.addr);
        h = e.addr[1] ? w[31:16] : w[15:0];
        y = w[8*e.addr[1:0] +: 8];
        exp = e.addr;
        case (e.op)
            LOAD: begin
                if (e.size == BYTE) begin
                    exp = e.uns ? {24'd0, y} : {{24{y[7]}}, y};
                end else if (e.size == HALF) begin
                    exp = e.uns ? {16'd0, h} : {{16{h[15]}}, h};
                end else begin
                    exp = w;
                end
            end
            STORE: begin
                if (e.size == BYTE) begin
                    ref_mem[b] = e.data[7:0];
                end else if (e.size == HALF) begin
                    ref_mem[{b[9:1], 1'b0}]     = e.data[7:0];
                    ref_mem[{b[9:1], 1'b0} + 1] = e.data[15:8];
                end else begin
                    for (int i = 0; i < 4; i++) ref_mem[{b[9:2], 2'b00} + i] = e.data[8*i +: 8];
                end
            end
            LOAD_LINKED: begin
                exp    = w;
                ref_ll = 1'b1;
            end
            STORE_COND: begin
                exp = {31'd0, ref_ll};
                if (ref_ll) begin
                    for (int i = 0; i < 4; i++) ref_mem[{b[9:2], 2'b00} + i] = e.data[8*i +: 8];
                end
                ref_ll = 1'b0;
            end
            default: exp = e.addr;
        endcase
    endtask

    task automatic run_entry(input int k, inout mem_wb_ctrl_t last_wb);
        entry_t      e;
        word_t       exp;
        mem_bypass_t byp;
        int          n;
        logic        got;
        logic        needs_ram;
        int          err0;
        e    = tbl[k];
        err0 = errors;
        // a failed sc is the only memory op that skips the ram
        needs_ram = (e.op == LOAD) || (e.op == STORE) || (e.op == LOAD_LINKED) ||
                    ((e.op == STORE_COND) && ref_ll);
        ex_ctrl_i = '{pc: 32'h1000 + 4 * k, alu_result: e.addr, store_data: e.data,
                      mem_op: e.op, mem_size: e.size, unsigned_ext: e.uns,
                      wreg_idx: e.wreg, wreg_en: 1'b1};
        left_valid_i  = 1'b1;
        flush_i       = 1'b0;
        right_ready_i = e.flush || (e.hold == 0);
        if (e.flush) begin
            // flush arrives in the cycle the load would otherwise complete
            repeat (`LSU_RAM_LATENCY) @(negedge clk);
            flush_i = 1'b1;
            @(negedge clk);
            flush_i      = 1'b0;
            left_valid_i = 1'b0;
            compare_value("right_valid_o", 32'd0, 32'(right_valid_o));
            repeat (`LSU_RAM_LATENCY + 2) @(negedge clk);
            compare_value("right_valid_o", 32'd0, 32'(right_valid_o));
        end else begin
            expected_fires++;
            got = 1'b0;
            n   = 0;
            while (!got && n < WAIT_LIMIT) begin
                @(posedge clk);
                got = is_fire_o;
                byp = bypass_o;
                @(negedge clk);
                n++;
                if (!got) begin
                    if (n == 1) begin
                        compare_value("left_ready_o", 32'(!needs_ram), 32'(left_ready_o));
                        compare_value("bypass_o.wen", 32'(!needs_ram), 32'(bypass_o.wen));
                    end
                    if (!right_ready_i && right_valid_o) begin
                        compare_value("wb_ctrl_o.pc", last_wb.pc, wb_ctrl_o.pc);
                        compare_value("wb_ctrl_o.result", last_wb.result, wb_ctrl_o.result);
                    end
                    if (n >= int'(e.hold)) right_ready_i = 1'b1;
                end
            end
            if (!got) begin
                $display("entry %0d timed out waiting for the write-back", k);
                errors++;
            end else begin
                model_entry(e, exp);
                compare_value("right_valid_o", 32'd1, 32'(right_valid_o));
                compare_value("wb_ctrl_o.pc", 32'h1000 + 4 * k, wb_ctrl_o.pc);
                compare_value("wb_ctrl_o.result", exp, wb_ctrl_o.result);
                compare_value("wb_ctrl_o.wreg_idx", 32'(e.wreg), 32'(wb_ctrl_o.wreg_idx));
                compare_value("wb_ctrl_o.wreg_en", 32'd1, 32'(wb_ctrl_o.wreg_en));
                compare_value("bypass_o.result", exp, byp.result);
                compare_value("bypass_o.wreg_idx", 32'(e.wreg), 32'(byp.wreg_idx));
                compare_value("bypass_o.wen", 32'd1, 32'(byp.wen));
                last_wb.pc       = 32'h1000 + 4 * k;
                last_wb.result   = exp;
                last_wb.wreg_idx = e.wreg;
                last_wb.wreg_en  = 1'b1;
            end
        end
        $display("entry %0d %s addr %h flush %0b: %s", k, e.op.name(), e.addr, e.flush,
                 (errors == err0) ? "ok" : "FAILED");
    endtask

    initial begin
        mem_wb_ctrl_t last_wb;
        lfsr           = 32'h1d59;
        errors         = 0;
        fire_count     = 0;
        expected_fires = 0;
        ref_ll         = 1'b0;
        last_wb        = '0;
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        left_valid_i   = 1'b0;
        right_ready_i  = 1'b0;
        ex_ctrl_i      = '0;

        // stores, then partial overwrites, then readback
        for (int a = 'h10; a <= 'h20; a += 4) add_entry(STORE, WORD, 1'b0, a, 1'b0);
        add_entry(STORE, HALF, 1'b0, 32'h12, 1'b0);
        add_entry(STORE, BYTE, 1'b0, 32'h15, 1'b0);
        add_entry(STORE, BYTE, 1'b0, 32'h1b, 1'b0);
        for (int a = 'h10; a <= 'h1c; a += 4) add_entry(LOAD, WORD, 1'b0, a, 1'b0);
        for (int o = 0; o < 8; o++) add_entry(LOAD, BYTE, o[0], 32'h18 + o / 2, 1'b0);
        for (int o = 0; o < 4; o++) add_entry(LOAD, HALF, o[0], 32'h10 + 2 * (o / 2), 1'b0);
        add_entry(NONE, WORD, 1'b0, 32'h14, 1'b0);
        add_entry(LOAD, WORD, 1'b0, 32'h14, 1'b0);
        add_entry(LOAD_LINKED, WORD, 1'b0, 32'h20, 1'b0);
        add_entry(STORE_COND, WORD, 1'b0, 32'h20, 1'b0);
        add_entry(STORE_COND, WORD, 1'b0, 32'h20, 1'b0);
        add_entry(LOAD, WORD, 1'b0, 32'h20, 1'b0);
        add_entry(LOAD, WORD, 1'b0, 32'h10, 1'b1);
        add_entry(LOAD, WORD, 1'b0, 32'h10, 1'b0);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        compare_value("left_ready_o", 32'd1, 32'(left_ready_o));
        compare_value("right_valid_o", 32'd0, 32'(right_valid_o));

        for (int k = 0; k < tbl.size(); k++) run_entry(k, last_wb);
        left_valid_i = 1'b0;
        @(negedge clk);
        compare_value("fire count", 32'(expected_fires), 32'(fire_count));

        $display("%0d entries, %0d errors", tbl.size(), errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
lsu_pkg.sv
mem_op_decode.sv
mem_access_exec.sv
load_result.sv
data_ram.sv
mem_stage_top.sv
mem_stage_assertions.sv
tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
RTL_TOP   ?= mem_stage_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
